/* Makefile */
# Verilator build and run for the md_unit testbench

VERILATOR ?= verilator
TOP       ?= md_unit_tb
FILELIST  ?= md_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "Simulation FAILED: run incomplete"; exit 1; }
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/md_ctrl.sv */
// Sequencer for the multiply/divide unit. Requests are only legal in IDLE,
// which the request credit guarantees. A finished result waits in FINISH
// until a response credit is held; datapath registers stay frozen meanwhile.
`default_nettype none

module md_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  md_pkg::md_req_t   req_i,
  output logic              req_credit_o,
  input  logic              rsp_credit_i,
  output logic              rsp_valid_o,
  output md_pkg::word_t     rsp_o,
  input  logic              den_zero_i,
  input  logic              last_step_i,
  input  md_pkg::word_t     mac_res_i,
  input  md_pkg::word_t     div_res_i,
  output md_pkg::md_req_t   req_q_o,
  output md_pkg::mac_ctl_t  mac_ctl_o,
  output md_pkg::div_step_e div_step_o
);
  import md_pkg::*;

  md_state_e state_q, state_d;
  md_req_t   req_q;
  rsp_cnt_t  rsp_cnt_q;
  logic      req_credit_q;
  logic      is_mull;
  logic      rsp_fire;

  assign is_mull  = (req_q.op == MD_OP_MULL);
  assign rsp_fire = (state_q == FINISH) && (rsp_cnt_q != '0);

  // Accepted request, held stable until the response goes out
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && req_valid_i) begin
      req_q <= req_i;
    end
  end

  always_comb begin
    state_d    = state_q;
    mac_ctl_o  = '0;
    div_step_o = DIV_NONE;

    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = (req_i.op inside {MD_OP_MULL, MD_OP_MULH}) ? ALBL : DIV_ABS_A;
        end
      end
      ALBL: begin
        mac_ctl_o.acc_sel = ACC_ZERO;
        mac_ctl_o.en      = 1'b1;
        state_d           = ALBH;
      end
      ALBH: begin
        mac_ctl_o.b_hi     = 1'b1;
        mac_ctl_o.acc_sel  = ACC_LOW;
        mac_ctl_o.pack_low = is_mull;
        mac_ctl_o.en       = 1'b1;
        state_d            = AHBL;
      end
      AHBL: begin
        mac_ctl_o.a_hi     = 1'b1;
        mac_ctl_o.acc_sel  = is_mull ? ACC_LOW : ACC_FULL;
        mac_ctl_o.pack_low = is_mull;
        mac_ctl_o.en       = 1'b1;
        state_d            = is_mull ? FINISH : AHBH;
      end
      AHBH: begin
        mac_ctl_o.a_hi    = 1'b1;
        mac_ctl_o.b_hi    = 1'b1;
        mac_ctl_o.acc_sel = ACC_TOP;
        mac_ctl_o.en      = 1'b1;
        state_d           = FINISH;
      end
      DIV_ABS_A: begin
        div_step_o = DIV_NEG_A;
        state_d    = DIV_ABS_B;
      end
      DIV_ABS_B: begin
        // Zero divisor loads the fixed RV32M result and skips the loop
        div_step_o = den_zero_i ? DIV_INIT : DIV_NEG_B;
        state_d    = den_zero_i ? FINISH : DIV_COMP;
      end
      DIV_COMP: begin
        div_step_o = DIV_STEP;
        if (last_step_i) begin
          state_d = DIV_LAST;
        end
      end
      DIV_LAST: begin
        div_step_o = DIV_FINAL;
        state_d    = DIV_SIGN;
      end
      DIV_SIGN: begin
        div_step_o = DIV_FIX;
        state_d    = FINISH;
      end
      FINISH: begin
        if (rsp_fire) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      rsp_cnt_q    <= '0;
      req_credit_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      // Request credit goes back in the first IDLE cycle after the response
      req_credit_q <= rsp_fire;
      if (rsp_credit_i && !rsp_fire && (rsp_cnt_q != rsp_cnt_t'(RSP_CREDITS_MAX))) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
      end else if (rsp_fire && !rsp_credit_i) begin
        rsp_cnt_q <= rsp_cnt_q - 1'b1;
      end
    end
  end

  assign req_q_o      = req_q;
  assign req_credit_o = req_credit_q;
  assign rsp_valid_o  = rsp_fire;
  assign rsp_o        = (req_q.op inside {MD_OP_DIV, MD_OP_REM}) ? div_res_i : mac_res_i;

endmodule

`default_nettype wire

/* design/md_div_dp.sv */
// Restoring long division on absolute values, one quotient bit per cycle.
// The remainder starts at zero, so the first compare always yields a zero bit
// that is shifted out of the quotient. Signs are fixed in a final step.
`default_nettype none

module md_div_dp (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  md_pkg::md_req_t   req_i,
  input  md_pkg::div_step_e step_i,
  output logic              den_zero_o,
  output logic              last_step_o,
  output md_pkg::word_t     res_o
);
  import md_pkg::*;

  word_t            num_q, den_q, quo_q, res_q;
  word_t            quo_next;
  acc_t             rem_q, rem_keep;
  acc_t             add_a, add_b, add_res;
  logic [CNT_W-1:0] cnt_q;
  logic             sign_a, sign_b;
  logic             ge;
  logic             quo_neg, rem_neg;
  logic             is_div;

  assign is_div = (req_i.op == MD_OP_DIV);
  assign sign_a = req_i.sign_mode[0] & req_i.op_a[31];
  assign sign_b = req_i.sign_mode[1] & req_i.op_b[31];

  assign den_zero_o  = (req_i.op_b == '0);
  assign last_step_o = (cnt_q == '0);

  assign quo_neg = (sign_a ^ sign_b) & ~den_zero_o;
  assign rem_neg = sign_a;

  // Single subtractor shared by negation, trial subtraction and sign fix
  always_comb begin
    add_a = '0;
    add_b = '0;
    case (step_i)
      DIV_NEG_A: add_b = {2'b0, req_i.op_a};
      DIV_NEG_B: add_b = {2'b0, req_i.op_b};
      DIV_STEP, DIV_FINAL: begin
        add_a = rem_q;
        add_b = {2'b0, den_q};
      end
      DIV_FIX: add_b = {2'b0, res_q};
      default: add_b = '0;
    endcase
  end

  assign add_res = add_a - add_b;

  // Remainder stays below 2^33, so a clear top bit means rem >= den
  assign ge       = ~add_res[33];
  assign rem_keep = ge ? add_res : rem_q;
  assign quo_next = {quo_q[30:0], ge};

  always_ff @(posedge clk_i) begin
    case (step_i)
      DIV_INIT: res_q <= is_div ? '1 : req_i.op_a;
      DIV_NEG_A: begin
        num_q <= sign_a ? add_res[31:0] : req_i.op_a;
        quo_q <= '0;
      end
      DIV_NEG_B: begin
        den_q <= sign_b ? add_res[31:0] : req_i.op_b;
        rem_q <= '0;
      end
      DIV_STEP: begin
        rem_q <= {rem_keep[32:0], num_q[cnt_q]};
        quo_q <= quo_next;
      end
      DIV_FINAL: res_q <= is_div ? quo_next : rem_keep[31:0];
      DIV_FIX: begin
        if (is_div ? quo_neg : rem_neg) begin
          res_q <= add_res[31:0];
        end
      end
      default: begin
        // Hold all values
      end
    endcase
  end

  // Counter points at the numerator bit shifted in next
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (step_i == DIV_NEG_B) begin
      cnt_q <= CNT_W'(DIV_STEPS - 1);
    end else if (step_i == DIV_STEP) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign res_o = res_q;

endmodule

`default_nettype wire

/* design/md_mac16.sv */
// 17x17 signed multiply-accumulate over the four 16-bit partial products.
// MULL finishes after AHBL with packed low halves; MULH needs AHBH as well.
`default_nettype none

module md_mac16 (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  md_pkg::md_req_t  req_i,
  input  md_pkg::mac_ctl_t ctl_i,
  output md_pkg::word_t    res_o
);
  import md_pkg::*;

  half_t             half_a, half_b;
  logic              ext_a, ext_b;
  logic              signed_mult;
  acc_t              acc_q, acc_d, addend;
  logic signed [33:0] mac_s;

  assign half_a = ctl_i.a_hi ? req_i.op_a[31:16] : req_i.op_a[15:0];
  assign half_b = ctl_i.b_hi ? req_i.op_b[31:16] : req_i.op_b[15:0];

  // Only an upper half of a signed operand carries the sign
  assign ext_a = ctl_i.a_hi & req_i.sign_mode[0] & half_a[15];
  assign ext_b = ctl_i.b_hi & req_i.sign_mode[1] & half_b[15];

  assign signed_mult = (req_i.sign_mode != 2'b00);

  always_comb begin
    case (ctl_i.acc_sel)
      ACC_ZERO: addend = '0;
      // Carry the upper 16 bits of the previous partial sum
      ACC_LOW:  addend = {18'b0, acc_q[31:16]};
      ACC_FULL: addend = acc_q;
      default:  addend = {{16{signed_mult & acc_q[33]}}, acc_q[33:16]};
    endcase
  end

  assign mac_s = $signed({ext_a, half_a}) * $signed({ext_b, half_b}) + $signed(addend);

  // MULL keeps the finished low half below the new partial sum
  assign acc_d = ctl_i.pack_low ? {2'b0, mac_s[15:0], acc_q[15:0]} : mac_s;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (ctl_i.en) begin
      acc_q <= acc_d;
    end
  end

  assign res_o = acc_q[31:0];

endmodule

`default_nettype wire

/* design/md_pkg.sv */
// Shared types and constants for the iterative RV32M multiply/divide unit.
// Only one operation is in flight at a time, so one request register is enough.
`default_nettype none

package md_pkg;

  // Data widths
  typedef logic [31:0] word_t;
  typedef logic [15:0] half_t;
  // Accumulator and remainder carry two guard bits
  typedef logic [33:0] acc_t;

  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Bit 0 marks operand a signed, bit 1 marks operand b signed
  typedef logic [1:0] sign_mode_t;

  typedef struct packed {
    md_op_e     op;
    sign_mode_t sign_mode;
    word_t      op_a;
    word_t      op_b;
  } md_req_t;

  typedef enum logic [3:0] {
    IDLE,
    ALBL,
    ALBH,
    AHBL,
    AHBH,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    FINISH
  } md_state_e;

  // Addend codes for the multiply-accumulate
  localparam logic [1:0] ACC_ZERO = 2'd0;
  localparam logic [1:0] ACC_LOW  = 2'd1;
  localparam logic [1:0] ACC_FULL = 2'd2;
  localparam logic [1:0] ACC_TOP  = 2'd3;

  typedef struct packed {
    logic       a_hi;
    logic       b_hi;
    logic [1:0] acc_sel;
    logic       pack_low;
    logic       en;
  } mac_ctl_t;

  typedef enum logic [2:0] {
    DIV_NONE,
    DIV_INIT,
    DIV_NEG_A,
    DIV_NEG_B,
    DIV_STEP,
    DIV_FINAL,
    DIV_FIX
  } div_step_e;

  localparam int unsigned DIV_STEPS       = 32;
  localparam int unsigned CNT_W           = 5;
  localparam int unsigned REQ_CREDITS     = 1;
  localparam int unsigned RSP_CREDITS_MAX = 4;

  // Response credit counter, wide enough to hold RSP_CREDITS_MAX
  typedef logic [$clog2(RSP_CREDITS_MAX + 1) - 1:0] rsp_cnt_t;

endpackage

`default_nettype wire

/* design/md_unit.sv */
// RV32M multiply/divide unit with credit flow control on both sides.
// The requester starts with REQ_CREDITS credits; the sink grants response
// credits by pulses, and the unit holds at most RSP_CREDITS_MAX of them.
`default_nettype none

module md_unit (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_valid_i,
  input  md_pkg::md_req_t req_i,
  output logic            req_credit_o,
  input  logic            rsp_credit_i,
  output logic            rsp_valid_o,
  output md_pkg::word_t   rsp_o
);
  import md_pkg::*;

  md_req_t   req_q;
  mac_ctl_t  mac_ctl;
  div_step_e div_step;
  logic      den_zero;
  logic      last_step;
  word_t     mac_res;
  word_t     div_res;

  md_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_credit_o (req_credit_o),
    .rsp_credit_i (rsp_credit_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .den_zero_i   (den_zero),
    .last_step_i  (last_step),
    .mac_res_i    (mac_res),
    .div_res_i    (div_res),
    .req_q_o      (req_q),
    .mac_ctl_o    (mac_ctl),
    .div_step_o   (div_step)
  );

  md_mac16 u_mac16 (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_q),
    .ctl_i  (mac_ctl),
    .res_o  (mac_res)
  );

  md_div_dp u_div_dp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_q),
    .step_i      (div_step),
    .den_zero_o  (den_zero),
    .last_step_o (last_step),
    .res_o       (div_res)
  );

endmodule

`default_nettype wire

/* md_unit.f */
design/md_pkg.sv
design/md_ctrl.sv
design/md_mac16.sv
design/md_div_dp.sv
design/md_unit.sv
verification/md_unit_tb.sv

/* verification/md_unit_tb.sv */
// Testbench for md_unit. All operations are built at time zero from a fixed seed.
// The sink never grants more than RSP_CREDITS_MAX credits ahead of the responses.
`default_nettype none

module md_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import md_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 8;
  localparam int NUM_CORNERS   = 4;
  localparam int NUM_RANDOM    = 200;
  // Four multiply modes and two divide modes, each for two ops over all corner pairs
  localparam int NUM_OPS       = 12 * NUM_CORNERS * NUM_CORNERS + NUM_RANDOM;
  localparam int CYCLES_PER_OP = 60;
  localparam int TIMEOUT_NS    = (RESET_CYCLES + NUM_OPS * CYCLES_PER_OP + 500) * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  logic       req_valid;
  md_req_t    req;
  logic       req_credit;
  logic       rsp_credit;
  logic       rsp_valid;
  word_t      rsp;

  integer     seed;
  integer     rnd;
  integer     rnd_credit;
  md_req_t    ops[$];
  word_t      exp_q[$];
  word_t      corners[NUM_CORNERS];
  word_t      rnd_a;
  word_t      rnd_b;
  md_op_e     rnd_op;
  sign_mode_t rnd_sm;
  int         req_credits;
  int         rsp_outstanding;
  int         rsp_count;
  int         stall_left;
  logic       credit_pending;
  logic       sent_any;
  logic       sink_on;

  md_unit uut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_credit_o (req_credit),
    .rsp_credit_i (rsp_credit),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // RV32M result from the 64-bit product or a truncating divide.
  // The most negative value over -1 wraps to itself with a zero remainder.
  function automatic word_t md_ref(md_op_e op, sign_mode_t sm, word_t a, word_t b);
    longint sa;
    longint sb;
    longint prod;
    longint quo;
    longint rem;
    word_t  res;
    sa   = sm[0] ? {{32{a[31]}}, a} : {32'b0, a};
    sb   = sm[1] ? {{32{b[31]}}, b} : {32'b0, b};
    prod = sa * sb;
    res  = '0;
    case (op)
      MD_OP_MULL: res = prod[31:0];
      MD_OP_MULH: res = prod[63:32];
      MD_OP_DIV: begin
        if (b == '0) begin
          res = '1;
        end else begin
          quo = sa / sb;
          res = quo[31:0];
        end
      end
      default: begin
        if (b == '0) begin
          res = a;
        end else begin
          rem = sa % sb;
          res = rem[31:0];
        end
      end
    endcase
    return res;
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string msg);
    $display("FAILURE: %s at %0t", msg, $time);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic add_op(input md_op_e op, input sign_mode_t sm, input word_t a, input word_t b);
    md_req_t r;
    r.op        = op;
    r.sign_mode = sm;
    r.op_a      = a;
    r.op_b      = b;
    ops.push_back(r);
  endtask

  // Called on a falling edge; holds the request until a credit is owned
  task automatic send_op(input md_req_t r);
    while (req_credits == 0) begin
      @(negedge clk);
    end
    req_valid = 1'b1;
    req       = r;
    req_credits--;
    sent_any  = 1'b1;
    exp_q.push_back(md_ref(r.op, r.sign_mode, r.op_a, r.op_b));
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // Response sink with random stretches of withheld credits
  always @(negedge clk) begin
    rsp_credit = 1'b0;
    if (sink_on) begin
      rnd_credit = $random(seed);
      if (stall_left > 0) begin
        stall_left--;
      end else if (rnd_credit[3:0] == 4'd0) begin
        stall_left = int'(rnd_credit[7:4]);
      end else if (rnd_credit[8] && (rsp_outstanding < int'(RSP_CREDITS_MAX))) begin
        rsp_credit = 1'b1;
      end
    end
  end

  // Compare process sampling at the rising edge
  always @(posedge clk) begin
    sink_on = rst_n;
    if (!sent_any && (rsp_valid || req_credit)) begin
      report_failure("response or request credit seen before the first request");
    end
    if (rsp_valid) begin
      if (rsp_outstanding == 0) begin
        report_failure("response sent without a response credit");
      end
      if (credit_pending) begin
        report_failure("second response before the request credit came back");
      end
      if (exp_q.size() == 0) begin
        report_failure("response without a pending request");
      end
      check_value("rsp_o", rsp, exp_q.pop_front());
      rsp_outstanding--;
      rsp_count++;
      credit_pending = 1'b1;
    end
    if (req_credit) begin
      if (!credit_pending) begin
        report_failure("request credit returned without a response");
      end
      credit_pending = 1'b0;
      req_credits++;
    end
    if (rsp_credit) begin
      rsp_outstanding++;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    report_failure("watchdog expired before all responses arrived");
  end

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    req_valid       = 1'b0;
    req             = '0;
    rsp_credit      = 1'b0;
    seed            = 32'h882a;
    req_credits     = int'(REQ_CREDITS);
    rsp_outstanding = 0;
    rsp_count       = 0;
    stall_left      = 0;
    credit_pending  = 1'b0;
    sent_any        = 1'b0;
    sink_on         = 1'b0;
    corners         = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

    // Multiplies of corner operands in all four sign modes
    for (int m = 0; m < 4; m++) begin
      foreach (corners[i]) begin
        foreach (corners[j]) begin
          add_op(MD_OP_MULL, sign_mode_t'(m), corners[i], corners[j]);
          add_op(MD_OP_MULH, sign_mode_t'(m), corners[i], corners[j]);
        end
      end
    end
    // Unsigned and signed divides with zero divisors and the overflow case
    for (int m = 0; m < 4; m += 3) begin
      foreach (corners[i]) begin
        foreach (corners[j]) begin
          add_op(MD_OP_DIV, sign_mode_t'(m), corners[i], corners[j]);
          add_op(MD_OP_REM, sign_mode_t'(m), corners[i], corners[j]);
        end
      end
    end
    repeat (NUM_RANDOM) begin
      rnd    = $random(seed);
      rnd_a  = $random(seed);
      rnd_b  = $random(seed);
      rnd_op = md_op_e'(rnd[1:0]);
      // Smaller divisors give longer quotients
      if (rnd[4]) begin
        rnd_b = rnd_b >> rnd[9:5];
      end
      if (rnd_op inside {MD_OP_DIV, MD_OP_REM}) begin
        rnd_sm = {2{rnd[2]}};
      end else begin
        rnd_sm = rnd[3:2];
      end
      add_op(rnd_op, rnd_sm, rnd_a, rnd_b);
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    foreach (ops[i]) begin
      send_op(ops[i]);
    end
    while ((rsp_count < ops.size()) || (req_credits < int'(REQ_CREDITS))) begin
      @(negedge clk);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire
